/* common/isa_pkg.sv */
// ISA package with opcode and ALU enums, instruction field widths and ALU control constants
package isa_pkg;

    // Datapath and register index widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int REG_COUNT  = 2 ** REG_ADDR_W;

    // Instruction field widths
    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;

    // Major opcodes of the five supported classes
    typedef enum logic [OPCODE_W-1:0] {
        OP_RTYPE  = 7'b0110011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111
    } opcode_e;

    // ALU class chosen by the main decoder
    typedef enum logic [1:0] {
        ALU_ADD    = 2'b00,
        ALU_BRANCH = 2'b01,
        ALU_FUNCT  = 2'b10,
        ALU_JUMP   = 2'b11
    } alu_op_e;

    // Resolved ALU function
    typedef enum logic [2:0] {
        FN_ADD = 3'd0,
        FN_SUB = 3'd1,
        FN_AND = 3'd2,
        FN_OR  = 3'd3,
        FN_XOR = 3'd4,
        FN_SLT = 3'd5
    } alu_fn_e;

    // Immediate forms of load and store
    localparam logic [FUNCT3_W-1:0] FUNCT3_IMM = 3'b001;

    // R-type funct3 codes, funct7 bit 5 picks sub over add
    localparam logic [FUNCT3_W-1:0] F3_ADD_SUB = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_SLT     = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_XOR     = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_OR      = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_AND     = 3'b111;

    // Branch conditions
    localparam logic [FUNCT3_W-1:0] F3_BEQ = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_BNE = 3'b001;

endpackage

/* common/pipe_pkg.sv */
// Pipeline package with the control word, the inter-stage payloads and the pipeline sizes
package pipe_pkg;

    import isa_pkg::*;

    // Data memory depth and word index width
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    // Edges from an accepted instruction to its writeback
    localparam int PIPE_DEPTH = 3;

    // Control word from the main decoder
    typedef struct packed {
        logic    branch;
        logic    reg_write;
        logic    mem_read;
        logic    mem_to_reg;
        alu_op_e alu_op;
        logic    mem_write;
        logic    alu_src;
        logic    is_imm;
    } ctrl_t;

    // Decode to execute
    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        logic [FUNCT3_W-1:0]   funct3;
        logic                  funct7b;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rs1_val;
        logic [XLEN-1:0]       rs2_val;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rd;
    } dec_ex_t;

    // Execute to memory
    // store_data also carries the immediate of a load-immediate
    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] rd;
    } ex_mem_t;

    // Writeback to the register file
    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage

/* decode/control_unit.sv */
// Main decoder turning opcode and funct3 into the pipeline control word
module control_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  opcode_e             opcode,
    input  logic [FUNCT3_W-1:0] funct3,
    output ctrl_t               ctrl
);

    always_comb
    begin
        // Unknown opcodes leave the word all zero
        ctrl = '0;
        case (opcode)
            OP_RTYPE:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_FUNCT;
            end
            OP_LOAD:
            begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_op     = ALU_ADD;
                ctrl.alu_src    = 1'b1;
                // Load-immediate skips the memory read
                ctrl.is_imm     = (funct3 == FUNCT3_IMM);
            end
            OP_STORE:
            begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_op    = ALU_ADD;
                ctrl.alu_src   = 1'b1;
                // Store-immediate writes imm instead of rs2
                ctrl.is_imm    = (funct3 == FUNCT3_IMM);
            end
            OP_BRANCH:
            begin
                ctrl.branch = 1'b1;
                // Compare by subtraction of rs1 and rs2
                ctrl.alu_op = ALU_BRANCH;
            end
            OP_JALR:
            begin
                // No link register written
                ctrl.branch = 1'b1;
                ctrl.alu_op = ALU_JUMP;
            end
            default:
            begin
                ctrl = '0;
            end
        endcase
    end

endmodule

/* decode/reg_file.sv */
// Register file with two read ports, one write port, hard-wired x0 and write-through
module reg_file
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [REG_ADDR_W-1:0] rs1_addr,
    input  logic [REG_ADDR_W-1:0] rs2_addr,
    output logic [XLEN-1:0]       rs1_data,
    output logic [XLEN-1:0]       rs2_data,
    input  wb_t                   wb
);

    // x0 has no storage
    logic [XLEN-1:0] regs [1:REG_COUNT-1];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 1; i < REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb.valid && (wb.rd != '0))
        begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Same-cycle write is bypassed to the readers
    assign rs1_data = (rs1_addr == '0) ? '0 :
                      (wb.valid && (wb.rd == rs1_addr)) ? wb.data : regs[rs1_addr];

    assign rs2_data = (rs2_addr == '0) ? '0 :
                      (wb.valid && (wb.rd == rs2_addr)) ? wb.data : regs[rs2_addr];

endmodule

/* decode/decode_stage.sv */
// Decode stage with field slicing, immediate generation, register read and the decode register
module decode_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic            instr_valid,
    input  logic [XLEN-1:0] instr,
    input  logic [XLEN-1:0] instr_pc,
    input  wb_t             wb,
    output dec_ex_t         dec_ex
);

    opcode_e               opcode;
    logic [FUNCT3_W-1:0]   funct3;
    logic                  funct7b;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       rs1_val;
    logic [XLEN-1:0]       rs2_val;
    ctrl_t                 ctrl;
    logic                  known_op;

    // Standard RV32 field positions
    assign opcode  = opcode_e'(instr[OPCODE_W-1:0]);
    assign rd      = instr[11:7];
    assign funct3  = instr[14:12];
    assign rs1     = instr[19:15];
    assign rs2     = instr[24:20];
    // Only bit 5 of funct7 matters for sub
    assign funct7b = instr[30];

    always_comb
    begin
        case (opcode)
            // I-type
            OP_LOAD, OP_JALR:
            begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            // S-type
            OP_STORE:
            begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            // B-type, offset in halfwords
            OP_BRANCH:
            begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            default:
            begin
                imm = '0;
            end
        endcase
    end

    control_unit u_control_unit (
        .opcode (opcode),
        .funct3 (funct3),
        .ctrl   (ctrl)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (rs1),
        .rs2_addr (rs2),
        .rs1_data (rs1_val),
        .rs2_data (rs2_val),
        .wb       (wb)
    );

    // Every known class sets at least one of these
    assign known_op = ctrl.reg_write | ctrl.mem_write | ctrl.branch;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            dec_ex <= '0;
        end
        else
        begin
            // Unknown opcode becomes a bubble
            dec_ex.valid   <= instr_valid && known_op;
            dec_ex.ctrl    <= ctrl;
            dec_ex.funct3  <= funct3;
            dec_ex.funct7b <= funct7b;
            dec_ex.pc      <= instr_pc;
            dec_ex.rs1_val <= rs1_val;
            dec_ex.rs2_val <= rs2_val;
            dec_ex.imm     <= imm;
            dec_ex.rd      <= rd;
        end
    end

endmodule

/* src/execute_stage.sv */
// Execute stage with the ALU, branch resolution, redirect pulse and the execute register
module execute_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  dec_ex_t         dec_ex,
    output ex_mem_t         ex_mem,
    output logic            redirect_valid,
    output logic [XLEN-1:0] redirect_pc
);

    alu_fn_e         alu_fn;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;
    logic            alu_zero;
    logic            taken;
    logic [XLEN-1:0] target;

    // ALU class and funct bits to a single function
    always_comb
    begin
        case (dec_ex.ctrl.alu_op)
            ALU_BRANCH:
            begin
                alu_fn = FN_SUB;
            end
            ALU_FUNCT:
            begin
                case (dec_ex.funct3)
                    F3_ADD_SUB: alu_fn = dec_ex.funct7b ? FN_SUB : FN_ADD;
                    F3_SLT:     alu_fn = FN_SLT;
                    F3_XOR:     alu_fn = FN_XOR;
                    F3_OR:      alu_fn = FN_OR;
                    F3_AND:     alu_fn = FN_AND;
                    default:    alu_fn = FN_ADD;
                endcase
            end
            // Address add for loads, stores and jumps
            default:
            begin
                alu_fn = FN_ADD;
            end
        endcase
    end

    assign op_a = dec_ex.rs1_val;
    assign op_b = dec_ex.ctrl.alu_src ? dec_ex.imm : dec_ex.rs2_val;

    always_comb
    begin
        case (alu_fn)
            FN_SUB:  alu_result = op_a - op_b;
            FN_AND:  alu_result = op_a & op_b;
            FN_OR:   alu_result = op_a | op_b;
            FN_XOR:  alu_result = op_a ^ op_b;
            FN_SLT:  alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_result = op_a + op_b;
        endcase
    end

    assign alu_zero = (alu_result == '0);

    // Branch condition and destination
    always_comb
    begin
        taken  = 1'b0;
        target = dec_ex.pc + dec_ex.imm;
        if (dec_ex.ctrl.alu_op == ALU_JUMP)
        begin
            // Jump base is rs1, not pc, with bit 0 cleared
            taken  = 1'b1;
            target = (dec_ex.rs1_val + dec_ex.imm) & ~{{(XLEN-1){1'b0}}, 1'b1};
        end
        else if (dec_ex.funct3 == F3_BEQ)
        begin
            taken = alu_zero;
        end
        else if (dec_ex.funct3 == F3_BNE)
        begin
            taken = !alu_zero;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ex_mem         <= '0;
            redirect_valid <= 1'b0;
            redirect_pc    <= '0;
        end
        else
        begin
            // One-cycle pulse for every taken control transfer
            redirect_valid    <= dec_ex.valid && dec_ex.ctrl.branch && taken;
            redirect_pc       <= target;
            ex_mem.valid      <= dec_ex.valid;
            ex_mem.ctrl       <= dec_ex.ctrl;
            ex_mem.alu_result <= alu_result;
            // Immediate forms carry imm in place of rs2
            ex_mem.store_data <= dec_ex.ctrl.is_imm ? dec_ex.imm : dec_ex.rs2_val;
            ex_mem.rd         <= dec_ex.rd;
        end
    end

endmodule

/* src/memory_stage.sv */
// Memory stage with the word data memory, store port and the writeback register
module memory_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  ex_mem_t         ex_mem,
    output wb_t             wb,
    output logic            store_valid,
    output logic [XLEN-1:0] store_addr,
    output logic [XLEN-1:0] store_data
);

    logic [XLEN-1:0]    dmem [DMEM_WORDS];
    logic [DMEM_AW-1:0] word_idx;
    logic [XLEN-1:0]    load_data;
    logic               do_store;

    // Byte address to word index, upper bits wrap
    assign word_idx = ex_mem.alu_result[DMEM_AW+1:2];
    assign do_store = ex_mem.valid && ex_mem.ctrl.mem_write;

    // Load-immediate takes the immediate riding in store_data
    assign load_data = (ex_mem.ctrl.mem_read && !ex_mem.ctrl.is_imm) ? dmem[word_idx]
                                                                     : ex_mem.store_data;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < DMEM_WORDS; i++)
            begin
                dmem[i] <= '0;
            end
            store_valid <= 1'b0;
            store_addr  <= '0;
            store_data  <= '0;
            wb          <= '0;
        end
        else
        begin
            // Memory write lands on the same edge as the store report
            if (do_store)
            begin
                dmem[word_idx] <= ex_mem.store_data;
            end
            store_valid <= do_store;
            store_addr  <= ex_mem.alu_result;
            store_data  <= ex_mem.store_data;
            // Writes to x0 never leave the stage
            wb.valid    <= ex_mem.valid && ex_mem.ctrl.reg_write && (ex_mem.rd != '0);
            wb.rd       <= ex_mem.rd;
            wb.data     <= ex_mem.ctrl.mem_to_reg ? load_data : ex_mem.alu_result;
        end
    end

endmodule

/* src/core_pipe.sv */
// Core top level chaining decode, execute and memory with writeback fed back to decode
module core_pipe
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  instr_valid,
    input  logic [XLEN-1:0]       instr,
    input  logic [XLEN-1:0]       instr_pc,
    output logic                  wb_valid,
    output logic [REG_ADDR_W-1:0] wb_rd,
    output logic [XLEN-1:0]       wb_data,
    output logic                  store_valid,
    output logic [XLEN-1:0]       store_addr,
    output logic [XLEN-1:0]       store_data,
    output logic                  redirect_valid,
    output logic [XLEN-1:0]       redirect_pc
);

    dec_ex_t dec_ex;
    ex_mem_t ex_mem;
    wb_t     wb;

    decode_stage u_decode_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .wb          (wb),
        .dec_ex      (dec_ex)
    );

    execute_stage u_execute_stage (
        .clk            (clk),
        .arst_n         (arst_n),
        .dec_ex         (dec_ex),
        .ex_mem         (ex_mem),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    memory_stage u_memory_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .ex_mem      (ex_mem),
        .wb          (wb),
        .store_valid (store_valid),
        .store_addr  (store_addr),
        .store_data  (store_data)
    );

    // Register write port also visible outside
    assign wb_valid = wb.valid;
    assign wb_rd    = wb.rd;
    assign wb_data  = wb.data;

endmodule

/* testbench/core_checker.sv */
// Checker that queues expected core events and compares them with the DUT output ports
module core_checker
    import isa_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  int                    cycle,
    input  logic                  exp_valid,
    input  logic [31:0]           exp_kind,
    input  logic [31:0]           exp_issue,
    input  logic [31:0]           exp_a,
    input  logic [31:0]           exp_b,
    input  logic                  wb_valid,
    input  logic [REG_ADDR_W-1:0] wb_rd,
    input  logic [XLEN-1:0]       wb_data,
    input  logic                  store_valid,
    input  logic [XLEN-1:0]       store_addr,
    input  logic [XLEN-1:0]       store_data,
    input  logic                  redirect_valid,
    input  logic [XLEN-1:0]       redirect_pc,
    output int                    mismatch_cnt,
    output int                    event_err_cnt,
    output int                    pending_cnt
);
    timeunit 1ns;
    timeprecision 1ps;

    // Event kinds as coded in the data file
    localparam int KIND_WB       = 2;
    localparam int KIND_STORE    = 3;
    localparam int KIND_REDIRECT = 4;

    // Cycles from issue to a visible event
    localparam int LAT_REDIRECT = 2;
    localparam int LAT_WB_STORE = 3;

    typedef struct packed {
        logic [31:0] due;
        logic [31:0] a;
        logic [31:0] b;
    } expect_t;

    expect_t wb_q[$];
    expect_t st_q[$];
    expect_t rd_q[$];

    initial
    begin
        mismatch_cnt  = 0;
        event_err_cnt = 0;
        pending_cnt   = 0;
    end

    task automatic compare_event(
        input string       what,
        input bit          due_now,
        input expect_t     item,
        input logic        valid,
        input logic [31:0] got_a,
        input logic [31:0] got_b,
        input string       a_name,
        input string       b_name,
        input bit          use_b
    );
        if (due_now && (valid !== 1'b1))
        begin
            event_err_cnt++;
            $display("Missing %s event due at cycle %0d", what, item.due);
        end
        else if (!due_now && (valid === 1'b1))
        begin
            event_err_cnt++;
            $display("Unexpected %s event at cycle %0d", what, cycle);
        end
        else if (due_now)
        begin
            if (got_a !== item.a)
            begin
                mismatch_cnt++;
                $display("Mismatch %s: expected 0x%08h, got 0x%08h at cycle %0d",
                         a_name, item.a, got_a, cycle);
            end
            // Redirect carries only a target
            if (use_b && (got_b !== item.b))
            begin
                mismatch_cnt++;
                $display("Mismatch %s: expected 0x%08h, got 0x%08h at cycle %0d",
                         b_name, item.b, got_b, cycle);
            end
        end
    endtask

    // Inputs from the driver are stable at the rising edge
    always @(posedge clk)
    begin : capture_expected
        expect_t item;
        if ((arst_n === 1'b1) && (exp_valid === 1'b1))
        begin
            item.a = exp_a;
            item.b = exp_b;
            case (exp_kind)
                KIND_WB:
                begin
                    item.due = exp_issue + LAT_WB_STORE;
                    wb_q.push_back(item);
                end
                KIND_STORE:
                begin
                    item.due = exp_issue + LAT_WB_STORE;
                    st_q.push_back(item);
                end
                KIND_REDIRECT:
                begin
                    item.due = exp_issue + LAT_REDIRECT;
                    rd_q.push_back(item);
                end
                // Issue with no event
                default:
                begin
                    item.due = '0;
                end
            endcase
        end
    end

    // DUT outputs settle well before the falling edge
    always @(negedge clk)
    begin : check_outputs
        bit      due_now;
        expect_t item;
        if (arst_n === 1'b1)
        begin
            due_now = (wb_q.size() > 0) && (wb_q[0].due == cycle);
            item    = due_now ? wb_q.pop_front() : '0;
            compare_event("writeback", due_now, item, wb_valid, {27'd0, wb_rd}, wb_data,
                          "wb_rd", "wb_data", 1'b1);
            due_now = (st_q.size() > 0) && (st_q[0].due == cycle);
            item    = due_now ? st_q.pop_front() : '0;
            compare_event("store", due_now, item, store_valid, store_addr, store_data,
                          "store_addr", "store_data", 1'b1);
            due_now = (rd_q.size() > 0) && (rd_q[0].due == cycle);
            item    = due_now ? rd_q.pop_front() : '0;
            compare_event("redirect", due_now, item, redirect_valid, redirect_pc, '0,
                          "redirect_pc", "", 1'b0);
            pending_cnt = wb_q.size() + st_q.size() + rd_q.size();
        end
    end

endmodule

/* testbench/tb_core.sv */
// Testbench for the core pipeline with clock, reset, watchdog, test file reader and driver
module tb_core
    import isa_pkg::*;
    import pipe_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY  = 2;
    localparam int FIELDS       = 5;
    localparam int MAX_LINES    = 64;
    localparam int KIND_IDLE    = 0;

    logic                  clk;
    logic                  arst_n;
    logic                  instr_valid;
    logic [XLEN-1:0]       instr;
    logic [XLEN-1:0]       instr_pc;
    logic                  wb_valid;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;
    logic                  store_valid;
    logic [XLEN-1:0]       store_addr;
    logic [XLEN-1:0]       store_data;
    logic                  redirect_valid;
    logic [XLEN-1:0]       redirect_pc;

    // Expected event handed to the checker with its issue cycle
    logic        exp_valid;
    logic [31:0] exp_kind;
    logic [31:0] exp_issue;
    logic [31:0] exp_a;
    logic [31:0] exp_b;

    logic [31:0] tests [0:MAX_LINES*FIELDS-1];
    int          num_lines;
    int          cycle = 0;
    int          seed;
    int unsigned scratch;
    int          load_err;
    bit          loaded = 1'b0;
    int          mismatch_cnt;
    int          event_err_cnt;
    int          pending_cnt;

    core_pipe u_dut (
        .clk            (clk),
        .arst_n         (arst_n),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .instr_pc       (instr_pc),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data),
        .store_valid    (store_valid),
        .store_addr     (store_addr),
        .store_data     (store_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    core_checker u_checker (
        .clk            (clk),
        .arst_n         (arst_n),
        .cycle          (cycle),
        .exp_valid      (exp_valid),
        .exp_kind       (exp_kind),
        .exp_issue      (exp_issue),
        .exp_a          (exp_a),
        .exp_b          (exp_b),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data),
        .store_valid    (store_valid),
        .store_addr     (store_addr),
        .store_data     (store_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .mismatch_cnt   (mismatch_cnt),
        .event_err_cnt  (event_err_cnt),
        .pending_cnt    (pending_cnt)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Shared cycle count for issue tags and due checks
    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    // Drive one slot of the stream
    task automatic drive_slot(input int line);
        int          base;
        logic [31:0] junk;
        base      = line * FIELDS;
        exp_issue = cycle;
        if (tests[base] == KIND_IDLE)
        begin
            junk        = $urandom;
            instr_valid = 1'b0;
            // Idle junk shaped as a load-immediate to the otherwise unused x31
            instr       = {junk[31:15], FUNCT3_IMM, 5'd31, OP_LOAD};
            instr_pc    = $urandom;
            exp_valid   = 1'b0;
        end
        else
        begin
            instr_valid = 1'b1;
            instr       = tests[base + 1];
            instr_pc    = tests[base + 2];
            exp_valid   = 1'b1;
            exp_kind    = tests[base];
            exp_a       = tests[base + 3];
            exp_b       = tests[base + 4];
        end
    endtask

    initial
    begin : run_tests
        int total;
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        instr_pc    = '0;
        exp_valid   = 1'b0;
        exp_kind    = '0;
        exp_issue   = '0;
        exp_a       = '0;
        exp_b       = '0;
        load_err    = 0;
        seed        = 6;
        scratch     = $urandom(seed);
        $readmemh("testbench/core_tests.txt", tests);
        // Lines end at the first word the file left unset
        num_lines = 0;
        while ((num_lines < MAX_LINES) && (tests[num_lines * FIELDS] !== {32{1'bx}}))
        begin
            num_lines++;
        end
        if (num_lines == 0)
        begin
            load_err = 1;
            $display("No test lines were read from testbench/core_tests.txt");
        end
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        arst_n = 1'b1;
        for (int i = 0; i < num_lines; i++)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            drive_slot(i);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        instr_valid = 1'b0;
        exp_valid   = 1'b0;
        // Let the last events leave the pipe
        repeat (PIPE_DEPTH + 2) @(posedge clk);
        @(negedge clk);
        #DRIVE_DELAY;
        total = mismatch_cnt + event_err_cnt + pending_cnt + load_err;
        $display("Error counts: %0d mismatches, %0d missing or unexpected, %0d unseen, %0d load",
                 mismatch_cnt, event_err_cnt, pending_cnt, load_err);
        if (total == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Limit counted from reset release
    initial
    begin : watchdog
        int limit;
        wait (loaded && (arst_n === 1'b1));
        limit = num_lines + PIPE_DEPTH + 20;
        #(limit * CLK_PERIOD);
        $display("Timeout: the run did not end within %0d clock periods", limit);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* testbench/core_tests.txt */
// Columns: kind instr pc a b, all hex
// kind 0 idle, 1 issue with no event, 2 writeback a=rd b=data, 3 store a=addr b=data, 4 redirect a=pc
2 00501083 00000100 00000001 00000005
2 FFD01103 00000104 00000002 FFFFFFFD
2 7F001183 00000108 00000003 000007F0
2 00C01203 0000010C 00000004 0000000C
1 0000007F 00000110 00000000 00000000
0 00000000 00000114 00000000 00000000
2 002082B3 00000118 00000005 00000002
2 40208333 0000011C 00000006 00000008
2 0040F3B3 00000120 00000007 00000004
2 0040E433 00000124 00000008 0000000D
2 0021C4B3 00000128 00000009 FFFFF80D
2 00112533 0000012C 0000000A 00000001
2 0020A5B3 00000130 0000000B 00000000
1 00108033 00000134 00000000 00000000
3 00122423 00000138 00000014 00000005
3 FE019E23 0000013C 000007EC FFFFFFFC
2 00822603 00000140 0000000C 00000005
2 FFC1A683 00000144 0000000D FFFFFFFC
4 00108863 00000148 00000158 00000000
1 00208863 0000014C 00000000 00000000
4 FE209CE3 00000150 00000148 00000000
1 00109863 00000154 00000000 00000000
4 003200E7 00000158 0000000E 00000000
1 0000000B 0000015C 00000000 00000000
0 00000000 00000160 00000000 00000000
2 00008733 00000164 0000000E 00000005
2 004007B3 00000168 0000000F 0000000C
2 00628833 0000016C 00000010 0000000A

/* files.f */
common/isa_pkg.sv
common/pipe_pkg.sv
decode/control_unit.sv
decode/reg_file.sv
decode/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/core_pipe.sv
testbench/core_checker.sv
testbench/tb_core.sv
